// File: logic/exu_pkg.sv
package exu_pkg;

    localparam int XLEN  = 64;
    localparam int OP_W  = 5;
    localparam int SEL_W = 3;

    // op, sel, rs1, rs2, imm, pc, snpc
    localparam int ISSUE_W = OP_W + SEL_W + 5 * XLEN;

    localparam logic [OP_W-1:0] OP_ZERO     = 5'd0;
    localparam logic [OP_W-1:0] OP_ADD      = 5'd1;
    localparam logic [OP_W-1:0] OP_ADD_CLR0 = 5'd2;  // jalr target
    localparam logic [OP_W-1:0] OP_SLL      = 5'd3;
    localparam logic [OP_W-1:0] OP_ADDW     = 5'd4;
    localparam logic [OP_W-1:0] OP_SUB      = 5'd5;
    localparam logic [OP_W-1:0] OP_SRA      = 5'd6;
    localparam logic [OP_W-1:0] OP_AND      = 5'd7;
    localparam logic [OP_W-1:0] OP_SLLW     = 5'd8;
    localparam logic [OP_W-1:0] OP_XOR      = 5'd9;
    localparam logic [OP_W-1:0] OP_OR       = 5'd10;
    localparam logic [OP_W-1:0] OP_SRL      = 5'd11;
    localparam logic [OP_W-1:0] OP_MULW     = 5'd12;
    localparam logic [OP_W-1:0] OP_MULHU    = 5'd13;
    localparam logic [OP_W-1:0] OP_MULHSU   = 5'd14;
    localparam logic [OP_W-1:0] OP_MULH     = 5'd15;
    localparam logic [OP_W-1:0] OP_MUL      = 5'd16;
    localparam logic [OP_W-1:0] OP_DIVW     = 5'd17;
    localparam logic [OP_W-1:0] OP_DIVUW    = 5'd18;
    localparam logic [OP_W-1:0] OP_DIVU     = 5'd19;
    localparam logic [OP_W-1:0] OP_DIV      = 5'd20;
    localparam logic [OP_W-1:0] OP_REMW     = 5'd21;
    localparam logic [OP_W-1:0] OP_REMUW    = 5'd22;
    localparam logic [OP_W-1:0] OP_REMU     = 5'd23;
    localparam logic [OP_W-1:0] OP_REM      = 5'd24;
    localparam logic [OP_W-1:0] OP_SUBW     = 5'd25;
    localparam logic [OP_W-1:0] OP_SLLIW    = 5'd26;
    localparam logic [OP_W-1:0] OP_SRAIW    = 5'd27;
    localparam logic [OP_W-1:0] OP_SRAW     = 5'd28;

    // operand source pairs, src1 first
    localparam logic [SEL_W-1:0] SEL_RS1_RS2  = 3'd0;
    localparam logic [SEL_W-1:0] SEL_RS1_IMM  = 3'd1;
    localparam logic [SEL_W-1:0] SEL_RS1_PC   = 3'd2;
    localparam logic [SEL_W-1:0] SEL_RS1_SNPC = 3'd3;
    localparam logic [SEL_W-1:0] SEL_IMM_PC   = 3'd4;
    localparam logic [SEL_W-1:0] SEL_IMM_SNPC = 3'd5;

endpackage

// File: logic/exu_shifter.sv
`timescale 1ns/1ps

module exu_shifter (
    input  logic [exu_pkg::OP_W-1:0] op,
    input  logic [exu_pkg::XLEN-1:0] src1,
    input  logic [exu_pkg::XLEN-1:0] src2,
    output logic [exu_pkg::XLEN-1:0] shift_result
);
    import exu_pkg::*;

    logic [5:0]  dw_shamt;
    logic [4:0]  w_shamt;
    logic [31:0] w_left;
    logic [31:0] w_arith;

    assign dw_shamt = src2[5:0];
    assign w_shamt  = src2[4:0];

    // word forms only see the low half of src1
    assign w_left  = src1[31:0] << w_shamt;
    assign w_arith = $signed(src1[31:0]) >>> w_shamt;

    always_comb begin
        case (op)
            OP_SLL: begin
                shift_result = src1 << dw_shamt;
            end
            OP_SRL: begin
                shift_result = src1 >> dw_shamt;
            end
            OP_SRA: begin
                shift_result = $signed(src1) >>> dw_shamt;
            end
            OP_SLLW, OP_SLLIW: begin
                shift_result = {{32{w_left[31]}}, w_left};  // sext
            end
            OP_SRAW, OP_SRAIW: begin
                shift_result = {{32{w_arith[31]}}, w_arith};
            end
            default: begin
                shift_result = '0;
            end
        endcase
    end

endmodule

// File: logic/exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
    input  logic [exu_pkg::OP_W-1:0]  op,
    input  logic [exu_pkg::SEL_W-1:0] sel,
    input  logic [exu_pkg::XLEN-1:0]  rs1_data,
    input  logic [exu_pkg::XLEN-1:0]  rs2_data,
    input  logic [exu_pkg::XLEN-1:0]  imm,
    input  logic [exu_pkg::XLEN-1:0]  pc,
    input  logic [exu_pkg::XLEN-1:0]  snpc,
    output logic [exu_pkg::XLEN-1:0]  result,
    output logic                      flag
);
    import exu_pkg::*;

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] shift_result;

    always_comb begin
        case (sel)
            SEL_RS1_IMM: begin
                src1 = rs1_data;
                src2 = imm;
            end
            SEL_RS1_PC: begin
                src1 = rs1_data;
                src2 = pc;
            end
            SEL_RS1_SNPC: begin
                src1 = rs1_data;
                src2 = snpc;
            end
            SEL_IMM_PC: begin  // auipc style
                src1 = imm;
                src2 = pc;
            end
            SEL_IMM_SNPC: begin
                src1 = imm;
                src2 = snpc;
            end
            default: begin
                src1 = rs1_data;
                src2 = rs2_data;
            end
        endcase
    end

    assign sum  = src1 + src2;
    assign diff = src1 - src2;
    assign flag = (src1 == src2);  // branch compare for decode

    exu_shifter u_shifter (
        .op           (op),
        .src1         (src1),
        .src2         (src2),
        .shift_result (shift_result)
    );

    always_comb begin
        case (op)
            OP_ADD: begin
                result = sum;
            end
            OP_ADD_CLR0: begin
                result = {sum[XLEN-1:1], 1'b0};
            end
            OP_ADDW: begin
                result = {{32{sum[31]}}, sum[31:0]};
            end
            OP_SUB: begin
                result = diff;
            end
            OP_SUBW: begin
                result = {{32{diff[31]}}, diff[31:0]};
            end
            OP_AND: begin
                result = src1 & src2;
            end
            OP_XOR: begin
                result = src1 ^ src2;
            end
            OP_OR: begin
                result = src1 | src2;
            end
            OP_SLL, OP_SRL, OP_SRA, OP_SLLW, OP_SLLIW, OP_SRAIW, OP_SRAW: begin
                result = shift_result;
            end
            default: begin
                result = '0;  // OP_ZERO, mul/div and unused codes
            end
        endcase
    end

endmodule

// File: logic/exu_muldiv.sv
`timescale 1ns/1ps

module exu_muldiv (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic [exu_pkg::OP_W-1:0] op,
    input  logic [exu_pkg::XLEN-1:0] src1,
    input  logic [exu_pkg::XLEN-1:0] src2,
    output logic                     busy,
    output logic                     done,
    output logic [exu_pkg::XLEN-1:0] result
);
    import exu_pkg::*;

    logic            is_word, is_div, is_rem, is_high;
    logic            a_signed, b_signed, a_neg, b_neg;
    logic            div_zero, div_ovf;
    logic [XLEN-1:0] a_ext, b_ext, a_mag, b_mag;
    logic [XLEN-1:0] quick_raw, quick_val;

    logic            word_q, div_q, rem_q, high_q, neg_q, neg_r_q;
    logic [5:0]      count;
    logic [127:0]    acc, mcand;
    logic [XLEN-1:0] mplier;
    logic [XLEN-1:0] rem, quo, divisor;

    logic [127:0]    acc_next, prod;
    logic [XLEN:0]   shifted, trial;
    logic [XLEN-1:0] rem_next, quo_next, mul_val, quo_val, rem_val, fin_raw, fin_val;

    assign is_word  = op inside {OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
    assign is_div   = (op >= OP_DIVW) && (op <= OP_REM);
    assign is_rem   = (op >= OP_REMW) && (op <= OP_REM);
    assign is_high  = op inside {OP_MULH, OP_MULHSU, OP_MULHU};
    assign a_signed = op inside {OP_MULH, OP_MULHSU, OP_DIV, OP_DIVW, OP_REM, OP_REMW};
    assign b_signed = op inside {OP_MULH, OP_DIV, OP_DIVW, OP_REM, OP_REMW};

    // word operands widened to 64 bits up front
    assign a_ext = !is_word ? src1 :
                   a_signed ? {{32{src1[31]}}, src1[31:0]} : {32'd0, src1[31:0]};
    assign b_ext = !is_word ? src2 :
                   b_signed ? {{32{src2[31]}}, src2[31:0]} : {32'd0, src2[31:0]};
    assign a_neg = a_signed && a_ext[XLEN-1];
    assign b_neg = b_signed && b_ext[XLEN-1];
    assign a_mag = a_neg ? -a_ext : a_ext;
    assign b_mag = b_neg ? -b_ext : b_ext;

    assign div_zero = is_div && (b_ext == '0);
    assign div_ovf  = is_div && a_signed && (b_ext == '1) &&
                      (is_word ? (a_ext == {{33{1'b1}}, 31'd0}) : (a_ext == {1'b1, 63'd0}));

    // RISC-V rules, no trap
    assign quick_raw = div_zero ? (is_rem ? a_ext : '1) : (is_rem ? '0 : a_ext);
    assign quick_val = is_word ? {{32{quick_raw[31]}}, quick_raw[31:0]} : quick_raw;

    assign acc_next = mplier[0] ? acc + mcand : acc;  // shift-add
    assign shifted  = {rem, quo[XLEN-1]};
    assign trial    = shifted - {1'b0, divisor};
    assign rem_next = trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];  // restore
    assign quo_next = {quo[XLEN-2:0], ~trial[XLEN]};

    assign prod    = neg_q ? -acc_next : acc_next;
    assign mul_val = high_q ? prod[127:64] : prod[63:0];
    assign quo_val = neg_q ? -quo_next : quo_next;
    assign rem_val = neg_r_q ? -rem_next : rem_next;  // sign follows dividend
    assign fin_raw = !div_q ? mul_val : (rem_q ? rem_val : quo_val);
    assign fin_val = word_q ? {{32{fin_raw[31]}}, fin_raw[31:0]} : fin_raw;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                count <= '0;
                if (div_zero || div_ovf) begin
                    done <= 1'b1;  // one cycle fast path
                end else begin
                    busy <= 1'b1;
                end
            end else if (busy) begin
                count <= count + 6'd1;
                if (count == 6'd63) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            word_q  <= is_word;
            div_q   <= is_div;
            rem_q   <= is_rem;
            high_q  <= is_high;
            neg_q   <= a_neg ^ b_neg;
            neg_r_q <= a_neg;
            acc     <= '0;
            mcand   <= {64'd0, b_mag};
            mplier  <= a_mag;
            rem     <= '0;
            quo     <= a_mag;
            divisor <= b_mag;
            result  <= quick_val;
        end else if (busy) begin
            if (div_q) begin
                rem <= rem_next;
                quo <= quo_next;
            end else begin
                acc    <= acc_next;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
            end
            if (count == 6'd63) begin
                result <= fin_val;
            end
        end
    end

endmodule

// File: logic/exu_issue_queue.sv
`timescale 1ns/1ps

module exu_issue_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        push,
    input  logic [exu_pkg::ISSUE_W-1:0] push_word,
    input  logic                        pop,
    output logic                        empty,
    output logic [exu_pkg::ISSUE_W-1:0] head_word,
    output logic                        op_credit
);
    import exu_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [ISSUE_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_pop;

    assign empty     = (count == '0);
    assign head_word = mem[rd_ptr];
    assign do_pop    = pop && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_word;  // sender holds a credit, never full
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            op_credit <= 1'b0;
        end else begin
            op_credit <= do_pop;  // one credit back per dequeue
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: logic/exu_top.sv
`timescale 1ns/1ps

module exu_top #(
    parameter int QUEUE_DEPTH    = 4,
    parameter int RESULT_CREDITS = 2
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      op_valid,
    input  logic [exu_pkg::OP_W-1:0]  op_code,
    input  logic [exu_pkg::SEL_W-1:0] op_sel,
    input  logic [exu_pkg::XLEN-1:0]  rs1_data,
    input  logic [exu_pkg::XLEN-1:0]  rs2_data,
    input  logic [exu_pkg::XLEN-1:0]  imm,
    input  logic [exu_pkg::XLEN-1:0]  pc,
    input  logic [exu_pkg::XLEN-1:0]  snpc,
    output logic                      op_credit,
    output logic                      result_valid,
    output logic [exu_pkg::XLEN-1:0]  result,
    output logic                      result_flag,
    input  logic                      result_credit
);
    import exu_pkg::*;

    localparam int CRED_W = $clog2(RESULT_CREDITS + 1);

    logic [ISSUE_W-1:0] head_word;
    logic [OP_W-1:0]    head_op;
    logic [SEL_W-1:0]   head_sel;
    logic [XLEN-1:0]    head_rs1, head_rs2, head_imm, head_pc, head_snpc;
    logic               queue_empty, dispatch, head_is_md;
    logic [CRED_W-1:0]  credits;
    logic [XLEN-1:0]    alu_result, alu_result_q, md_result;
    logic               alu_flag, alu_flag_q, alu_valid_q;
    logic               md_busy, md_done;

    exu_issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (op_valid),
        .push_word ({op_code, op_sel, rs1_data, rs2_data, imm, pc, snpc}),
        .pop       (dispatch),
        .empty     (queue_empty),
        .head_word (head_word),
        .op_credit (op_credit)
    );

    assign {head_op, head_sel, head_rs1, head_rs2, head_imm, head_pc, head_snpc} = head_word;

    assign head_is_md = (head_op >= OP_MULW) && (head_op <= OP_REM);
    assign dispatch   = !queue_empty && (credits != '0) && !md_busy;  // md blocks for order

    exu_alu u_alu (
        .op       (head_op),
        .sel      (head_sel),
        .rs1_data (head_rs1),
        .rs2_data (head_rs2),
        .imm      (head_imm),
        .pc       (head_pc),
        .snpc     (head_snpc),
        .result   (alu_result),
        .flag     (alu_flag)
    );

    exu_muldiv u_muldiv (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (dispatch && head_is_md),
        .op     (head_op),
        .src1   (head_rs1),  // M ops always read rs1/rs2
        .src2   (head_rs2),
        .busy   (md_busy),
        .done   (md_done),
        .result (md_result)
    );

    always_ff @(posedge clk) begin
        alu_result_q <= alu_result;
        alu_flag_q   <= alu_flag;
    end

    // slot reserved at dispatch, so back-to-back ALU ops never overrun
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_valid_q <= 1'b0;
            credits     <= CRED_W'(RESULT_CREDITS);
        end else begin
            alu_valid_q <= dispatch && !head_is_md;
            if (dispatch && !result_credit) begin
                credits <= credits - 1'b1;
            end else if (!dispatch && result_credit) begin
                credits <= credits + 1'b1;
            end
        end
    end

    assign result_valid = alu_valid_q || md_done;  // never both in one cycle
    assign result       = md_done ? md_result : alu_result_q;
    assign result_flag  = md_done ? 1'b0 : alu_flag_q;

endmodule

// File: bench/exu_checker.sv
`timescale 1ns/1ps

module exu_checker #(
    parameter int QUEUE_DEPTH    = 4,
    parameter int RESULT_CREDITS = 2
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     op_valid,
    input  logic [exu_pkg::OP_W-1:0] op_code,
    input  logic                     op_credit,
    input  logic                     result_valid,
    input  logic [exu_pkg::XLEN-1:0] result,
    input  logic                     result_flag,
    input  logic                     result_credit,
    input  logic [exu_pkg::XLEN-1:0] exp_result,
    input  logic                     exp_flag,
    input  logic                     wrap_up,
    output int                       results_seen,
    output int                       errors,
    output logic                     summary_done
);
    import exu_pkg::*;

    logic [XLEN-1:0] exp_res_q [$];
    logic            exp_flag_q [$];
    logic [OP_W-1:0] exp_op_q [$];
    int              avail;       // result slots the consumer has granted
    int              op_credits;
    int              issued;
    int              passed;
    logic [XLEN-1:0] want;
    logic            want_flag;
    logic [OP_W-1:0] want_op;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_res_q.delete();
            exp_flag_q.delete();
            exp_op_q.delete();
            avail        = RESULT_CREDITS;
            op_credits   = 0;
            issued       = 0;
            passed       = 0;
            results_seen = 0;
            errors       = 0;
            summary_done = 1'b0;
        end else begin
            if (op_valid) begin
                exp_res_q.push_back(exp_result);
                exp_flag_q.push_back(exp_flag);
                exp_op_q.push_back(op_code);
                issued++;
            end
            if (op_credit) begin
                op_credits++;
            end
            if (result_valid) begin
                results_seen++;
                if (avail == 0) begin
                    $display("Credit violation at %0t: result sent with no result credit left",
                             $time);
                    errors++;
                end else begin
                    avail--;
                end
                if (exp_res_q.size() == 0) begin
                    $display("Extra result at %0t: more results than requests issued", $time);
                    errors++;
                end else begin
                    want      = exp_res_q.pop_front();
                    want_flag = exp_flag_q.pop_front();
                    want_op   = exp_op_q.pop_front();
                    if (result !== want || result_flag !== want_flag) begin
                        $display("** Error at %0t: test %0d op %0d got %h flag %b, exp %h flag %b",
                                 $time, results_seen, want_op, result, result_flag, want, want_flag);
                        errors++;
                    end else begin
                        $display("test %0d op %0d ok: %h flag %b",
                                 results_seen, want_op, result, result_flag);
                        passed++;
                    end
                end
            end
            // at most one dispatched request has no result yet
            if (issued - results_seen - 1 > QUEUE_DEPTH) begin
                $display("Queue overrun at %0t: %0d issued, %0d results out, depth %0d",
                         $time, issued, results_seen, QUEUE_DEPTH);
                errors++;
            end
            if (result_credit) begin
                avail++;  // counts from the next edge on
            end
            if (wrap_up && !summary_done) begin
                if (exp_res_q.size() != 0) begin
                    $display("Missing results: %0d requests never produced a result",
                             exp_res_q.size());
                    errors++;
                end
                if (op_credits != issued) begin
                    $display("Issue credit mismatch: %0d op_credit pulses for %0d requests",
                             op_credits, issued);
                    errors++;
                end
                $display("Checked %0d results: %0d passed, %0d errors",
                         results_seen, passed, errors);
                summary_done = 1'b1;
            end
        end
    end

endmodule

// File: bench/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    localparam int QUEUE_DEPTH    = 4;
    localparam int RESULT_CREDITS = 2;
    localparam int NUM_PATS       = 37;
    localparam int FIELDS         = 9;  // words per pattern line
    localparam int TIMEOUT_CYCLES = NUM_PATS * 70 + 200;
    localparam int DRAIN_CYCLES   = 100;  // longer than any mul/div gap

    logic             clk;
    logic             arst_n;
    logic             op_valid;
    logic [OP_W-1:0]  op_code;
    logic [SEL_W-1:0] op_sel;
    logic [XLEN-1:0]  rs1_data, rs2_data, imm, pc, snpc;
    logic             op_credit;
    logic             result_valid;
    logic [XLEN-1:0]  result;
    logic             result_flag;
    logic             result_credit = 1'b0;
    logic [XLEN-1:0]  exp_result;
    logic             exp_flag;
    logic             wrap_up;
    int               results_seen;
    int               errors;
    logic             summary_done;

    logic [XLEN-1:0]  pats [NUM_PATS * FIELDS];
    int               ret_delay [NUM_PATS];
    int               due_q [$];
    int               ret_cycle = 0;
    int               ret_count = 0;
    int               hit;
    int               cycle_count;
    int               issue_credits;
    int               idx;
    int               base;
    int               quiet;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    exu_top #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .RESULT_CREDITS (RESULT_CREDITS)
    ) DUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .op_valid      (op_valid),
        .op_code       (op_code),
        .op_sel        (op_sel),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .imm           (imm),
        .pc            (pc),
        .snpc          (snpc),
        .op_credit     (op_credit),
        .result_valid  (result_valid),
        .result        (result),
        .result_flag   (result_flag),
        .result_credit (result_credit)
    );

    exu_checker #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .RESULT_CREDITS (RESULT_CREDITS)
    ) u_checker (
        .clk           (clk),
        .arst_n        (arst_n),
        .op_valid      (op_valid),
        .op_code       (op_code),
        .op_credit     (op_credit),
        .result_valid  (result_valid),
        .result        (result),
        .result_flag   (result_flag),
        .result_credit (result_credit),
        .exp_result    (exp_result),
        .exp_flag      (exp_flag),
        .wrap_up       (wrap_up),
        .results_seen  (results_seen),
        .errors        (errors),
        .summary_done  (summary_done)
    );

    initial begin
        arst_n     = 1'b0;
        op_valid   = 1'b0;
        op_code    = '0;
        op_sel     = '0;
        rs1_data   = '0;
        rs2_data   = '0;
        imm        = '0;
        pc         = '0;
        snpc       = '0;
        exp_result = '0;
        exp_flag   = 1'b0;
        wrap_up    = 1'b0;
        void'($urandom(32'h6227934c));
        for (int i = 0; i < NUM_PATS; i++) begin
            ret_delay[i] = $urandom % 6;
        end
        $readmemh("bench/exu_patterns.txt", pats);
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        issue_credits = QUEUE_DEPTH;
        idx = 0;
        while (idx < NUM_PATS) begin
            @(posedge clk);
            if (op_credit) begin
                issue_credits++;
            end
            op_valid <= 1'b0;
            if (issue_credits > 0) begin
                base = idx * FIELDS;
                op_valid   <= 1'b1;
                op_code    <= pats[base][OP_W-1:0];
                op_sel     <= pats[base + 1][SEL_W-1:0];
                rs1_data   <= pats[base + 2];
                rs2_data   <= pats[base + 3];
                imm        <= pats[base + 4];
                pc         <= pats[base + 5];
                snpc       <= pats[base + 6];
                exp_result <= pats[base + 7];
                exp_flag   <= pats[base + 8][0];
                issue_credits--;
                idx++;
            end
        end
        @(posedge clk);
        op_valid <= 1'b0;
        quiet = 0;
        while (results_seen < NUM_PATS && quiet < DRAIN_CYCLES) begin
            @(posedge clk);
            if (result_valid) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        repeat (8) @(posedge clk);  // room for stray results
        wrap_up <= 1'b1;
        wait (summary_done);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // consumer hands result slots back after a short random wait
    always @(posedge clk) begin
        result_credit <= 1'b0;
        if (arst_n) begin
            ret_cycle++;
            if (result_valid) begin
                due_q.push_back(ret_cycle + ret_delay[ret_count % NUM_PATS]);
                ret_count++;
            end
            hit = -1;
            foreach (due_q[i]) begin
                if (hit < 0 && due_q[i] <= ret_cycle) begin
                    hit = i;
                end
            end
            if (hit >= 0) begin
                due_q.delete(hit);
                result_credit <= 1'b1;  // one slot per cycle
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not end within %0d cycles, %0d of %0d results seen",
                 TIMEOUT_CYCLES, results_seen, NUM_PATS);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: bench/exu_patterns.txt
// each line is one request in hex
// op sel rs1 rs2 imm pc snpc expected_result expected_flag
01 0 5 7 100 1000 1004 c 0
01 1 5 7 100 1000 1004 105 0
01 2 5 7 100 1000 1004 1005 0
01 3 5 7 100 1000 1004 1009 0
01 4 5 7 100 1000 1004 1100 0
01 5 5 7 100 1000 1004 1104 0
02 1 2001 0 10 0 0 2010 0
03 0 1 7f 0 0 0 8000000000000000 0
04 0 7fffffff 1 0 0 0 ffffffff80000000 0
05 0 3 5 0 0 0 fffffffffffffffe 0
05 0 1234 1234 0 0 0 0 1
06 0 8000000000000000 4 0 0 0 f800000000000000 0
07 0 ff00ff f0f0f 0 0 0 f000f 0
08 0 ffffffff00000001 1f 0 0 0 ffffffff80000000 0
09 0 ff00 ff0 0 0 0 f0f0 0
0a 0 f000 f 0 0 0 f00f 0
0b 0 8000000000000000 3f 0 0 0 1 0
19 0 1 2 0 0 0 ffffffffffffffff 0
1a 1 3 0 1e 0 0 ffffffffc0000000 0
1b 1 80000000 0 4 0 0 fffffffff8000000 0
1c 0 70000000 24 0 0 0 7000000 0
10 0 fffffffffffffffd 7 0 0 0 ffffffffffffffeb 0
0f 0 8000000000000000 8000000000000000 0 0 0 4000000000000000 0
0d 0 ffffffffffffffff ffffffffffffffff 0 0 0 fffffffffffffffe 0
0e 0 fffffffffffffffe 8000000000000000 0 0 0 ffffffffffffffff 0
0c 0 ffffffff00010000 8000 0 0 0 ffffffff80000000 0
14 0 fffffffffffffff9 2 0 0 0 fffffffffffffffd 0
18 0 fffffffffffffff9 2 0 0 0 ffffffffffffffff 0
13 0 64 7 0 0 0 e 0
14 0 1234 0 0 0 0 ffffffffffffffff 0
18 0 1234 0 0 0 0 1234 0
14 0 8000000000000000 ffffffffffffffff 0 0 0 8000000000000000 0
18 0 8000000000000000 ffffffffffffffff 0 0 0 0 0
11 0 80000000 ffffffff 0 0 0 ffffffff80000000 0
12 0 fffffffe 1 0 0 0 fffffffffffffffe 0
15 0 fffffff9 3 0 0 0 ffffffffffffffff 0
16 0 80000005 100000000 0 0 0 ffffffff80000005 0

// File: all.f
logic/exu_pkg.sv
logic/exu_shifter.sv
logic/exu_alu.sv
logic/exu_muldiv.sv
logic/exu_issue_queue.sv
logic/exu_top.sv
bench/exu_checker.sv
bench/exu_tb.sv
